// File: design/mc_pkg.sv
`default_nettype none

package mc_pkg;

    // Cluster size and core index width
    localparam int NUM_CORES = 4;
    localparam int CORE_ID_W = 2;

    // Shared bus geometry, word addressed
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;

    // Command opcodes accepted by each engine
    typedef enum logic [1:0] {
        OP_READ  = 2'b00,
        OP_WRITE = 2'b01,
        OP_INC   = 2'b10
    } mem_op_e;

    // Engine sequencing states
    typedef enum logic [2:0] {
        ST_IDLE  = 3'b000,
        ST_READ  = 3'b001,
        ST_WRITE = 3'b010,
        ST_DONE  = 3'b011
    } engine_state_e;

endpackage

`default_nettype wire

// File: design/cmd_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_dispatch (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          cmd_valid,
    input  logic [mc_pkg::CORE_ID_W-1:0]                  cmd_core,
    input  mc_pkg::mem_op_e                               cmd_op,
    input  logic [mc_pkg::ADDR_W-1:0]                     cmd_addr,
    input  logic [mc_pkg::DATA_W-1:0]                     cmd_data,
    input  logic [mc_pkg::NUM_CORES-1:0]                  busy,
    output logic [mc_pkg::NUM_CORES-1:0]                  start,
    output mc_pkg::mem_op_e [mc_pkg::NUM_CORES-1:0]       op_q,
    output logic [mc_pkg::NUM_CORES*mc_pkg::ADDR_W-1:0]   addr_q,
    output logic [mc_pkg::NUM_CORES*mc_pkg::DATA_W-1:0]   data_q,
    output logic                                          cmd_drop
);
    import mc_pkg::*;

    logic [NUM_CORES-1:0] core_sel;
    logic                 target_busy;
    logic                 accept;

    // One-hot select of the addressed core
    always_comb begin
        core_sel = '0;
        core_sel[cmd_core] = 1'b1;
    end

    assign target_busy = |(busy & core_sel);
    assign accept      = cmd_valid && !target_busy;

    // Start or drop pulse, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start    <= '0;
            cmd_drop <= 1'b0;
        end else begin
            start    <= accept ? core_sel : '0;
            cmd_drop <= cmd_valid && target_busy;
        end
    end

    // Command fields land in the slot of the accepted core only
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CORES; i++) begin
            if (accept && core_sel[i]) begin
                op_q[i]                    <= cmd_op;
                addr_q[i*ADDR_W +: ADDR_W] <= cmd_addr;
                data_q[i*DATA_W +: DATA_W] <= cmd_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mem_engine.sv
`timescale 1ns/100ps
`default_nettype none

module mem_engine (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  mc_pkg::mem_op_e            op,
    input  logic [mc_pkg::ADDR_W-1:0]  addr,
    input  logic [mc_pkg::DATA_W-1:0]  wdata,
    output logic                       req,
    output logic                       req_we,
    output logic [mc_pkg::ADDR_W-1:0]  req_adr,
    output logic [mc_pkg::DATA_W-1:0]  req_dat_w,
    input  logic                       gnt_ack,
    input  logic                       gnt_err,
    input  logic [mc_pkg::DATA_W-1:0]  rsp_dat,
    output logic                       busy,
    output logic                       done,
    output logic                       err,
    output logic [mc_pkg::DATA_W-1:0]  rdata
);
    import mc_pkg::*;

    engine_state_e     state;
    mem_op_e           op_r;
    logic [ADDR_W-1:0] addr_r;
    logic [DATA_W-1:0] data_r;
    logic              err_r;

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            err_r <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        err_r <= 1'b0;
                        // Writes skip the read phase
                        state <= (op == OP_WRITE) ? ST_WRITE : ST_READ;
                    end
                end
                ST_READ: begin
                    if (gnt_err) begin
                        // Failed read ends the command, no write follows
                        err_r <= 1'b1;
                        state <= ST_DONE;
                    end else if (gnt_ack) begin
                        state <= (op_r == OP_INC) ? ST_WRITE : ST_DONE;
                    end
                end
                ST_WRITE: begin
                    if (gnt_err) begin
                        err_r <= 1'b1;
                        state <= ST_DONE;
                    end else if (gnt_ack) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            op_r   <= op;
            addr_r <= addr;
            data_r <= wdata;
        end else if (state == ST_READ && gnt_ack) begin
            // Increment result is both the write data and the reported value
            if (op_r == OP_INC) begin
                data_r <= rsp_dat + DATA_W'(1);
            end else begin
                data_r <= rsp_dat;
            end
        end
    end

    // Request port toward the adapter
    assign req       = (state == ST_READ) || (state == ST_WRITE);
    assign req_we    = (state == ST_WRITE);
    assign req_adr   = addr_r;
    assign req_dat_w = data_r;

    // Status toward the outside
    assign busy  = (state != ST_IDLE);
    assign done  = (state == ST_DONE);
    assign err   = err_r;
    assign rdata = data_r;

endmodule

`default_nettype wire

// File: design/wishbone_adapter.sv
`timescale 1ns/100ps
`default_nettype none

module wishbone_adapter (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [mc_pkg::NUM_CORES-1:0]                  req,
    input  logic [mc_pkg::NUM_CORES-1:0]                  req_we,
    input  logic [mc_pkg::NUM_CORES*mc_pkg::ADDR_W-1:0]   req_adr,
    input  logic [mc_pkg::NUM_CORES*mc_pkg::DATA_W-1:0]   req_dat_w,
    output logic [mc_pkg::NUM_CORES-1:0]                  gnt_ack,
    output logic [mc_pkg::NUM_CORES-1:0]                  gnt_err,
    output logic [mc_pkg::DATA_W-1:0]                     rsp_dat,

    output logic [mc_pkg::ADDR_W-1:0]                     wb_adr,
    output logic [mc_pkg::DATA_W-1:0]                     wb_dat_w,
    output logic [mc_pkg::DATA_W/8-1:0]                   wb_sel,
    output logic                                          wb_cyc,
    output logic                                          wb_stb,
    output logic                                          wb_we,
    input  logic [mc_pkg::DATA_W-1:0]                     wb_dat_r,
    input  logic                                          wb_ack,
    input  logic                                          wb_err
);
    import mc_pkg::*;

    logic                 cyc_r;
    logic [CORE_ID_W-1:0] gnt_idx;
    logic [CORE_ID_W-1:0] next_idx;
    logic                 found;
    logic [NUM_CORES-1:0] gnt_onehot;

    // Round-robin search, starting after the last granted core
    always_comb begin
        logic [CORE_ID_W-1:0] cand;
        next_idx = gnt_idx;
        found    = 1'b0;
        for (int k = 1; k <= NUM_CORES; k++) begin
            cand = CORE_ID_W'((int'(gnt_idx) + k) % NUM_CORES);
            if (!found && req[cand]) begin
                next_idx = cand;
                found    = 1'b1;
            end
        end
    end

    // Bus cycle tracking and grant lock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cyc_r   <= 1'b0;
            gnt_idx <= CORE_ID_W'(NUM_CORES - 1);
        end else if (cyc_r) begin
            // Cycle closes the edge after ack or err
            if (wb_ack || wb_err) begin
                cyc_r <= 1'b0;
            end
        end else if (found) begin
            cyc_r   <= 1'b1;
            gnt_idx <= next_idx;
        end
    end

    always_comb begin
        gnt_onehot = '0;
        gnt_onehot[gnt_idx] = 1'b1;
    end

    // Granted request onto the shared master
    assign wb_cyc   = cyc_r;
    assign wb_stb   = cyc_r;
    assign wb_we    = req_we[gnt_idx];
    assign wb_adr   = req_adr[gnt_idx*ADDR_W +: ADDR_W];
    assign wb_dat_w = req_dat_w[gnt_idx*DATA_W +: DATA_W];
    assign wb_sel   = '1;

    // Responses go back to the granted engine only
    assign gnt_ack = (cyc_r && wb_ack) ? gnt_onehot : '0;
    assign gnt_err = (cyc_r && wb_err) ? gnt_onehot : '0;
    assign rsp_dat = wb_dat_r;

endmodule

`default_nettype wire

// File: design/multicore_wrapper.sv
`timescale 1ns/100ps
`default_nettype none

module multicore_wrapper (
    input  logic                                          clk,
    input  logic                                          rst_n,

    input  logic                                          cmd_valid,
    input  logic [mc_pkg::CORE_ID_W-1:0]                  cmd_core,
    input  mc_pkg::mem_op_e                               cmd_op,
    input  logic [mc_pkg::ADDR_W-1:0]                     cmd_addr,
    input  logic [mc_pkg::DATA_W-1:0]                     cmd_data,
    output logic                                          cmd_drop,

    output logic [mc_pkg::NUM_CORES-1:0]                  busy,
    output logic [mc_pkg::NUM_CORES-1:0]                  done,
    output logic [mc_pkg::NUM_CORES-1:0]                  err,
    output logic [mc_pkg::NUM_CORES*mc_pkg::DATA_W-1:0]   rdata,

    output logic [mc_pkg::ADDR_W-1:0]                     wb_adr,
    output logic [mc_pkg::DATA_W-1:0]                     wb_dat_w,
    output logic [mc_pkg::DATA_W/8-1:0]                   wb_sel,
    output logic                                          wb_cyc,
    output logic                                          wb_stb,
    output logic                                          wb_we,
    input  logic [mc_pkg::DATA_W-1:0]                     wb_dat_r,
    input  logic                                          wb_ack,
    input  logic                                          wb_err
);
    import mc_pkg::*;

    // Dispatcher to engines
    logic [NUM_CORES-1:0]        start;
    mem_op_e [NUM_CORES-1:0]     op_q;
    logic [NUM_CORES*ADDR_W-1:0] addr_q;
    logic [NUM_CORES*DATA_W-1:0] data_q;

    // Engines to adapter and back
    logic [NUM_CORES-1:0]        req;
    logic [NUM_CORES-1:0]        req_we;
    logic [NUM_CORES*ADDR_W-1:0] req_adr;
    logic [NUM_CORES*DATA_W-1:0] req_dat_w;
    logic [NUM_CORES-1:0]        gnt_ack;
    logic [NUM_CORES-1:0]        gnt_err;
    logic [DATA_W-1:0]           rsp_dat;

    cmd_dispatch i_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_core  (cmd_core),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .busy      (busy),
        .start     (start),
        .op_q      (op_q),
        .addr_q    (addr_q),
        .data_q    (data_q),
        .cmd_drop  (cmd_drop)
    );

    generate for (genvar i = 0; i < NUM_CORES; i++) begin : gen_cores
        mem_engine i_engine (
            .clk       (clk),
            .rst_n     (rst_n),
            .start     (start[i]),
            .op        (op_q[i]),
            .addr      (addr_q[i*ADDR_W +: ADDR_W]),
            .wdata     (data_q[i*DATA_W +: DATA_W]),
            .req       (req[i]),
            .req_we    (req_we[i]),
            .req_adr   (req_adr[i*ADDR_W +: ADDR_W]),
            .req_dat_w (req_dat_w[i*DATA_W +: DATA_W]),
            .gnt_ack   (gnt_ack[i]),
            .gnt_err   (gnt_err[i]),
            .rsp_dat   (rsp_dat),
            .busy      (busy[i]),
            .done      (done[i]),
            .err       (err[i]),
            .rdata     (rdata[i*DATA_W +: DATA_W])
        );
    end endgenerate

    wishbone_adapter i_wb_adapter (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_we    (req_we),
        .req_adr   (req_adr),
        .req_dat_w (req_dat_w),
        .gnt_ack   (gnt_ack),
        .gnt_err   (gnt_err),
        .rsp_dat   (rsp_dat),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .wb_err    (wb_err)
    );

endmodule

`default_nettype wire

// File: dv/wb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mem_model (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [mc_pkg::ADDR_W-1:0]     wb_adr,
    input  logic [mc_pkg::DATA_W-1:0]     wb_dat_w,
    input  logic [mc_pkg::DATA_W/8-1:0]   wb_sel,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    output logic [mc_pkg::DATA_W-1:0]     wb_dat_r,
    output logic                          wb_ack,
    output logic                          wb_err
);
    import mc_pkg::*;

    // Word addresses with this bit set answer with err
    localparam int ERR_BIT = 29;

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    logic              active;
    logic [1:0]        delay;

    // Contents of a word that was never written
    function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] a);
        return {2'b10, a} ^ {a[14:0], 17'h0} ^ 32'h3c5a_0f96;
    endfunction

    // One access at a time, answered after a random wait of 0 to 3 cycles
    always @(posedge clk) begin
        wb_ack <= 1'b0;
        wb_err <= 1'b0;
        if (!rst_n) begin
            active   <= 1'b0;
            wb_dat_r <= '0;
        end else if (wb_cyc && wb_stb && !wb_ack && !wb_err) begin
            if (!active) begin
                active <= 1'b1;
                delay  <= 2'($urandom_range(0, 3));
            end else if (delay != 2'd0) begin
                delay <= delay - 2'd1;
            end else begin
                active <= 1'b0;
                if (wb_adr[ERR_BIT]) begin
                    wb_err <= 1'b1;
                end else begin
                    wb_ack <= 1'b1;
                    if (wb_we) begin
                        mem[wb_adr] = wb_dat_w;
                    end else begin
                        wb_dat_r <= mem.exists(wb_adr) ? mem[wb_adr] : init_word(wb_adr);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_multicore.sv
`timescale 1ns/100ps
`default_nettype none

module tb_multicore;
    import mc_pkg::*;

    localparam int NUM_CMDS       = 300;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * 40;
    localparam int ERR_BIT        = 29;

    logic                        clk;
    logic                        rst_n;
    logic                        cmd_valid;
    logic [CORE_ID_W-1:0]        cmd_core;
    mem_op_e                     cmd_op;
    logic [ADDR_W-1:0]           cmd_addr;
    logic [DATA_W-1:0]           cmd_data;
    logic                        cmd_drop;
    logic [NUM_CORES-1:0]        busy;
    logic [NUM_CORES-1:0]        done;
    logic [NUM_CORES-1:0]        err;
    logic [NUM_CORES*DATA_W-1:0] rdata;
    logic [ADDR_W-1:0]           wb_adr;
    logic [DATA_W-1:0]           wb_dat_w;
    logic [DATA_W/8-1:0]         wb_sel;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [DATA_W-1:0]           wb_dat_r;
    logic                        wb_ack;
    logic                        wb_err;

    // Reference model state
    logic [DATA_W-1:0]    shadow [logic [ADDR_W-1:0]];
    logic [NUM_CORES-1:0] in_flight;
    int                   age [NUM_CORES];
    int                   accesses [NUM_CORES];
    mem_op_e              pend_op [NUM_CORES];
    logic [ADDR_W-1:0]    pend_addr [NUM_CORES];
    logic [DATA_W-1:0]    pend_data [NUM_CORES];
    logic [1:0]           drop_pipe;
    logic                 prev_cyc;
    logic                 prev_end;
    logic                 prev_we;
    logic [ADDR_W-1:0]    prev_adr;
    int                   issued;
    int                   accepted;
    int                   completed;
    int                   dropped;
    int                   cycle_count;

    multicore_wrapper i_dut (.*);
    wb_mem_model i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_data(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // Same fill as the slave memory
    function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] a);
        return {2'b10, a} ^ {a[14:0], 17'h0} ^ 32'h3c5a_0f96;
    endfunction

    function automatic logic [DATA_W-1:0] shadow_read(input logic [ADDR_W-1:0] a);
        return shadow.exists(a) ? shadow[a] : init_word(a);
    endfunction

    // Core index in bits 9:8 keeps each core in its own window
    function automatic logic [ADDR_W-1:0] core_addr(input logic [CORE_ID_W-1:0] c,
                                                    input logic bad, input logic [3:0] offs);
        logic [ADDR_W-1:0] a;
        a          = '0;
        a[ERR_BIT] = bad;
        a[9:8]     = c;
        a[3:0]     = offs;
        return a;
    endfunction

    // Expected result of the finished command, shadow updated on success
    task automatic retire_command(input int c);
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] exp_data;
        logic              exp_err;
        int                exp_acc;
        a        = pend_addr[c];
        exp_err  = a[ERR_BIT];
        exp_data = pend_data[c];
        if (!exp_err) begin
            case (pend_op[c])
                OP_READ: exp_data = shadow_read(a);
                OP_INC: begin
                    exp_data  = shadow_read(a) + 32'd1;
                    shadow[a] = exp_data;
                end
                default: shadow[a] = exp_data;
            endcase
        end
        // One access per command, two for a successful increment
        exp_acc = (pend_op[c] == OP_INC && !exp_err) ? 2 : 1;
        check_flag($sformatf("core %0d err", c), err[c], exp_err);
        check_flag($sformatf("core %0d bus access count of %0d", c, exp_acc),
                   accesses[c] == exp_acc, 1'b1);
        if (!exp_err) begin
            check_data($sformatf("core %0d rdata", c), rdata[c*DATA_W +: DATA_W], exp_data);
        end
        in_flight[c] = 1'b0;
        completed++;
    endtask

    // All output checks, sampled mid-cycle
    task automatic observe();
        int                bus_core;
        logic [DATA_W-1:0] exp_wr;
        @(negedge clk);
        check_flag("cmd_drop", cmd_drop, drop_pipe[1]);
        drop_pipe = {drop_pipe[0], 1'b0};
        check_flag("wb_stb", wb_stb, wb_cyc);
        check_flag("wb_sel all ones", &wb_sel, 1'b1);
        if (prev_cyc && prev_end) begin
            check_flag("wb_cyc after ack or err", wb_cyc, 1'b0);
        end else if (prev_cyc && wb_cyc) begin
            check_flag("request held during cycle",
                       (wb_adr == prev_adr) && (wb_we == prev_we), 1'b1);
        end
        prev_cyc = wb_cyc;
        prev_end = wb_ack || wb_err;
        prev_adr = wb_adr;
        prev_we  = wb_we;
        // Every bus access belongs to an outstanding command of the core it addresses
        if (wb_cyc) begin
            bus_core = int'(wb_adr[9:8]);
            check_flag("bus access from a busy core", in_flight[bus_core], 1'b1);
            check_flag("bus address", wb_adr == pend_addr[bus_core], 1'b1);
            if (wb_we) begin
                check_flag("write access allowed",
                           pend_op[bus_core] == OP_WRITE
                           || (pend_op[bus_core] == OP_INC && !pend_addr[bus_core][ERR_BIT]),
                           1'b1);
                exp_wr = (pend_op[bus_core] == OP_INC) ? shadow_read(wb_adr) + 32'd1
                                                       : pend_data[bus_core];
                check_data("wb_dat_w", wb_dat_w, exp_wr);
            end
            if (wb_ack || wb_err) begin
                accesses[bus_core]++;
            end
        end
        for (int c = 0; c < NUM_CORES; c++) begin
            if (in_flight[c]) begin
                age[c]++;
            end
            if (done[c] && !in_flight[c]) begin
                $display("Core %0d pulsed done with no accepted command outstanding", c);
                stop_on_error();
            end
            // busy rises three observations after the command was driven
            check_flag($sformatf("core %0d busy", c), busy[c], in_flight[c] && age[c] >= 3);
            if (done[c]) begin
                retire_command(c);
            end
        end
    endtask

    task automatic drive_cycle(input logic v, input logic [CORE_ID_W-1:0] c, input mem_op_e op,
                               input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(posedge clk);
        cmd_valid <= v;
        cmd_core  <= c;
        cmd_op    <= op;
        cmd_addr  <= a;
        cmd_data  <= d;
        observe();
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, OP_READ, '0, '0);
    endtask

    // A core with a command outstanding must drop this one
    task automatic issue(input logic [CORE_ID_W-1:0] c, input mem_op_e op,
                         input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        if (in_flight[c]) begin
            drop_pipe[0] = 1'b1;
            dropped++;
        end else begin
            in_flight[c] = 1'b1;
            age[c]       = 0;
            accesses[c]  = 0;
            pend_op[c]   = op;
            pend_addr[c] = a;
            pend_data[c] = d;
            accepted++;
        end
        issued++;
        drive_cycle(1'b1, c, op, a, d);
    endtask

    task automatic wait_done(input int c);
        while (in_flight[c]) begin
            idle_cycle();
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        stop_on_error();
    end

    initial begin
        logic [CORE_ID_W-1:0] c;
        mem_op_e              op;
        logic [ADDR_W-1:0]    a;
        void'($urandom(70));
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_core  = '0;
        cmd_op    = OP_READ;
        cmd_addr  = '0;
        cmd_data  = '0;
        in_flight = '0;
        drop_pipe = '0;
        prev_cyc  = 1'b0;
        prev_end  = 1'b0;
        prev_we   = 1'b0;
        prev_adr  = '0;
        issued    = 0;
        accepted  = 0;
        completed = 0;
        dropped   = 0;
        for (int i = 0; i < NUM_CORES; i++) begin
            age[i]      = 0;
            accesses[i] = 0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        observe();

        // Write then read back
        issue(2'd0, OP_WRITE, core_addr(2'd0, 1'b0, 4'h1), 32'hcafe_0001);
        wait_done(0);
        issue(2'd0, OP_READ, core_addr(2'd0, 1'b0, 4'h1), '0);
        wait_done(0);
        // Increment then read
        issue(2'd1, OP_INC, core_addr(2'd1, 1'b0, 4'h2), '0);
        wait_done(1);
        issue(2'd1, OP_READ, core_addr(2'd1, 1'b0, 4'h2), '0);
        wait_done(1);
        // Error window, nothing may be written
        issue(2'd2, OP_WRITE, core_addr(2'd2, 1'b1, 4'h3), 32'h1234_5678);
        wait_done(2);
        issue(2'd2, OP_INC, core_addr(2'd2, 1'b1, 4'h3), '0);
        wait_done(2);
        issue(2'd2, OP_READ, core_addr(2'd2, 1'b0, 4'h3), '0);
        wait_done(2);
        // Second command while the first is running
        issue(2'd3, OP_INC, core_addr(2'd3, 1'b0, 4'h4), '0);
        while (age[3] < 2) begin
            idle_cycle();
        end
        issue(2'd3, OP_WRITE, core_addr(2'd3, 1'b0, 4'h4), 32'hdead_beef);
        wait_done(3);
        issue(2'd3, OP_READ, core_addr(2'd3, 1'b0, 4'h4), '0);
        wait_done(3);

        // Random traffic on all cores
        while (issued < NUM_CMDS) begin
            c = CORE_ID_W'($urandom % NUM_CORES);
            if (!in_flight[c] && ($urandom % 4 != 0)) begin
                op = mem_op_e'(2'($urandom % 3));
                a  = core_addr(c, ($urandom % 8) == 0, 4'($urandom));
                issue(c, op, a, $urandom);
            end else if (in_flight[c] && age[c] >= 2 && ($urandom % 6 == 0)) begin
                issue(c, OP_WRITE, core_addr(c, 1'b0, 4'h0), $urandom);
            end else begin
                idle_cycle();
            end
        end
        while (in_flight != '0) begin
            idle_cycle();
        end
        repeat (2) idle_cycle();

        if (completed != accepted || dropped == 0) begin
            $display("Accepted %0d commands but saw %0d done pulses and %0d drops",
                     accepted, completed, dropped);
            stop_on_error();
        end else begin
            $display("%0d commands: %0d completed, %0d dropped", issued, completed, dropped);
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src.f
design/mc_pkg.sv
design/cmd_dispatch.sv
design/mem_engine.sv
design/wishbone_adapter.sv
design/multicore_wrapper.sv
dv/wb_mem_model.sv
dv/tb_multicore.sv

// File: run.sh
#!/bin/sh
# Build the cluster testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing -f src.f --top-module tb_multicore -o sim_multicore \
    && ./obj_dir/sim_multicore | grep "TEST PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
